//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module tb_cdc_fifo

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_cdc_fifo -Mdir obj_dir
	-./obj_dir/Vtb_cdc_fifo > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  logic                wr_clk,
  input  logic                rst,
  fifo_write_if.fifo         wp,
  input  logic                rd_clk,
  input  logic                rd_en,
  output cdc_fifo_pkg::word_t rd_word,
  output logic                rd_valid,
  output logic                empty,
  output logic                aempty
);

  function automatic cdc_fifo_pkg::ptr_t bin2gray(input cdc_fifo_pkg::ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic cdc_fifo_pkg::ptr_t gray2bin(input cdc_fifo_pkg::ptr_t gray);
    cdc_fifo_pkg::ptr_t bin;
    bin[cdc_fifo_pkg::addr_width] = gray[cdc_fifo_pkg::addr_width];
    for (int i = cdc_fifo_pkg::addr_width - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // Write side.
  cdc_fifo_pkg::ptr_t wr_bin;
  cdc_fifo_pkg::ptr_t wr_bin_nxt;
  cdc_fifo_pkg::ptr_t wr_gray;
  cdc_fifo_pkg::ptr_t wr_gray_nxt;
  cdc_fifo_pkg::ptr_t rd_gray_w1;
  cdc_fifo_pkg::ptr_t rd_gray_w2;
  cdc_fifo_pkg::ptr_t rd_bin_w;
  cdc_fifo_pkg::ptr_t wr_used_nxt;
  cdc_fifo_pkg::ptr_t full_match;
  logic               wr_vld;

  // Read side.
  logic               rd_rst_meta;
  logic               rd_rst;
  cdc_fifo_pkg::ptr_t rd_bin;
  cdc_fifo_pkg::ptr_t rd_bin_nxt;
  cdc_fifo_pkg::ptr_t rd_gray;
  cdc_fifo_pkg::ptr_t rd_gray_nxt;
  cdc_fifo_pkg::ptr_t wr_gray_r1;
  cdc_fifo_pkg::ptr_t wr_gray_r2;
  cdc_fifo_pkg::ptr_t wr_bin_r;
  cdc_fifo_pkg::ptr_t rd_used_nxt;
  logic               rd_vld;

  assign wr_vld      = wp.wr_en && !wp.full;
  assign wr_bin_nxt  = wr_bin + cdc_fifo_pkg::ptr_t'(wr_vld);
  assign wr_gray_nxt = bin2gray(wr_bin_nxt);
  assign rd_bin_w    = gray2bin(rd_gray_w2);
  assign wr_used_nxt = wr_bin_nxt - rd_bin_w;

  // Full when the two top Gray bits differ and the rest match.
  assign full_match = {~rd_gray_w2[cdc_fifo_pkg::addr_width -: 2],
                       rd_gray_w2[cdc_fifo_pkg::addr_width-2:0]};

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      wp.full    <= 1'b0;
      wp.afull   <= 1'b0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= wr_gray_nxt;
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      wp.full    <= (wr_gray_nxt == full_match);
      wp.afull   <= (wr_used_nxt >= cdc_fifo_pkg::fifo_afull);
    end
  end

  // Reset crossing into rd_clk.
  always_ff @(posedge rd_clk) begin
    rd_rst_meta <= rst;
    rd_rst      <= rd_rst_meta;
  end

  assign rd_vld      = rd_en && !empty;
  assign rd_bin_nxt  = rd_bin + cdc_fifo_pkg::ptr_t'(rd_vld);
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);
  assign wr_bin_r    = gray2bin(wr_gray_r2);
  assign rd_used_nxt = wr_bin_r - rd_bin_nxt;

  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      empty      <= 1'b1;
      aempty     <= 1'b1;
      rd_valid   <= 1'b0;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= rd_gray_nxt;
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      empty      <= (rd_gray_nxt == wr_gray_r2);
      aempty     <= (rd_used_nxt <= cdc_fifo_pkg::fifo_aempty);
      rd_valid   <= rd_vld;
    end
  end

  dualport_ram_async dualport_ram_inst (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[cdc_fifo_pkg::addr_width-1:0]),
    .wr_data (wp.wr_word),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[cdc_fifo_pkg::addr_width-1:0]),
    .rd_data (rd_word)
  );

  // Accepted writes only land while fewer than fifo_depth words are stored.
  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (rst)
      wr_vld |-> cdc_fifo_pkg::ptr_t'(wr_bin - rd_bin_w) < cdc_fifo_pkg::fifo_depth
  );

  // Gray pointer moves by at most one code step per wr_clk.
  a_wr_ptr_step: assert property (
    @(posedge wr_clk) disable iff (rst) $onehot0(wr_gray ^ $past(wr_gray))
  );

  // Each rd_valid pulse comes from a read of a published entry.
  a_rd_valid_entry: assert property (
    @(posedge rd_clk) disable iff (rd_rst) rd_valid |-> $past(rd_bin != wr_bin_r)
  );

endmodule

`default_nettype wire

//--- hdl/cdc_fifo_pkg.sv
`default_nettype none

package cdc_fifo_pkg;

  localparam int data_width   = 8;
  localparam int num_channels = 2;
  localparam int fifo_depth   = 16;
  localparam int addr_width   = $clog2(fifo_depth);

  // Flag thresholds in entries.
  localparam int fifo_afull  = fifo_depth - 1;
  localparam int fifo_aempty = 1;

  typedef logic [data_width-1:0] data_t;
  typedef logic [0:0]            chan_t;

  // Channel number sits above the payload.
  typedef logic [$bits(chan_t)+data_width-1:0] word_t;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [addr_width:0]   ptr_t;

endpackage

`default_nettype wire

//--- hdl/cdc_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_top (
  input  logic                                                wr_clk,
  input  logic                                                rd_clk,
  input  logic                                                rst,
  input  logic [cdc_fifo_pkg::num_channels-1:0]               ch_wr_en,
  input  cdc_fifo_pkg::data_t [cdc_fifo_pkg::num_channels-1:0] ch_wr_data,
  output logic [cdc_fifo_pkg::num_channels-1:0]               ch_busy,
  output logic                                                full,
  output logic                                                afull,
  input  logic                                                rd_en,
  output cdc_fifo_pkg::data_t                                 rd_data,
  output cdc_fifo_pkg::chan_t                                 rd_chan,
  output logic                                                rd_valid,
  output logic                                                empty,
  output logic                                                aempty
);

  cdc_fifo_pkg::word_t rd_word;

  fifo_write_if wr_port_if ();

  write_arbiter write_arbiter_inst (
    .wr_clk     (wr_clk),
    .rst        (rst),
    .ch_wr_en   (ch_wr_en),
    .ch_wr_data (ch_wr_data),
    .ch_busy    (ch_busy),
    .wp         (wr_port_if.arbiter)
  );

  async_fifo async_fifo_inst (
    .wr_clk   (wr_clk),
    .rst      (rst),
    .wp       (wr_port_if.fifo),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_word  (rd_word),
    .rd_valid (rd_valid),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Channel tag is the top bit of the word.
  assign {rd_chan, rd_data} = rd_word;

  assign full  = wr_port_if.full;
  assign afull = wr_port_if.afull;

endmodule

`default_nettype wire

//--- hdl/dualport_ram_async.sv
`timescale 1ns/1ps
`default_nettype none

module dualport_ram_async (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::word_t wr_data,
  input  logic                rd_clk,
  input  logic                rd_en,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::word_t rd_data
);

  cdc_fifo_pkg::word_t mem [cdc_fifo_pkg::fifo_depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, one rd_clk of latency.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/fifo_write_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_write_if;

  logic                wr_en;
  cdc_fifo_pkg::word_t wr_word;
  logic                full;
  logic                afull;

  modport arbiter (
    output wr_en,
    output wr_word,
    input  full,
    input  afull
  );

  modport fifo (
    input  wr_en,
    input  wr_word,
    output full,
    output afull
  );

endinterface

`default_nettype wire

//--- hdl/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
  input  logic                                                wr_clk,
  input  logic                                                rst,
  input  logic [cdc_fifo_pkg::num_channels-1:0]               ch_wr_en,
  input  cdc_fifo_pkg::data_t [cdc_fifo_pkg::num_channels-1:0] ch_wr_data,
  output logic [cdc_fifo_pkg::num_channels-1:0]               ch_busy,
  fifo_write_if.arbiter                                       wp
);

  typedef enum logic {
    last_ch0,
    last_ch1
  } arb_state_t;

  cdc_fifo_pkg::data_t [cdc_fifo_pkg::num_channels-1:0] pend_data;
  logic [cdc_fifo_pkg::num_channels-1:0]                pend;
  logic [cdc_fifo_pkg::num_channels-1:0]                grant;
  arb_state_t                                           last_q;
  cdc_fifo_pkg::chan_t                                  sel_ch;
  logic                                                 can_write;

  // A write already in flight may take the last free slot.
  assign can_write = !wp.full && !(wp.wr_en && wp.afull);

  always_comb begin
    grant = '0;
    if (can_write) begin
      if (pend[0] && pend[1]) begin
        if (last_q == last_ch0) begin
          grant[1] = 1'b1;
        end else begin
          grant[0] = 1'b1;
        end
      end else begin
        grant = pend;
      end
    end
  end

  assign sel_ch  = cdc_fifo_pkg::chan_t'(grant[1]);
  assign ch_busy = pend;

  always_ff @(posedge wr_clk) begin
    for (int i = 0; i < cdc_fifo_pkg::num_channels; i++) begin
      if (ch_wr_en[i] && !pend[i]) begin
        pend_data[i] <= ch_wr_data[i];
      end
    end
    wp.wr_word <= {sel_ch, pend_data[sel_ch]};
  end

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      pend     <= '0;
      last_q   <= last_ch1;
      wp.wr_en <= 1'b0;
    end else begin
      for (int i = 0; i < cdc_fifo_pkg::num_channels; i++) begin
        if (grant[i]) begin
          pend[i] <= 1'b0;
        end else if (ch_wr_en[i]) begin
          pend[i] <= 1'b1;
        end
      end
      wp.wr_en <= |grant;
      if (grant[0]) begin
        last_q <= last_ch0;
      end else if (grant[1]) begin
        last_q <= last_ch1;
      end
    end
  end

  a_no_strobe_when_busy: assert property (
    @(posedge wr_clk) disable iff (rst) (ch_wr_en & ch_busy) == '0
  );

  // Full comes from the FIFO, one register behind our own wr_en.
  a_no_wr_en_when_full: assert property (
    @(posedge wr_clk) disable iff (rst) wp.wr_en |-> !wp.full
  );

endmodule

`default_nettype wire

//--- project.f
hdl/cdc_fifo_pkg.sv
hdl/fifo_write_if.sv
hdl/dualport_ram_async.sv
hdl/async_fifo.sv
hdl/write_arbiter.sv
hdl/cdc_fifo_top.sv
testbench/tb_cdc_fifo.sv

//--- testbench/tb_cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_fifo;

  // The five tests need well under 5000 wr_clk cycles.
  localparam int timeout_cycles = 20000;

  logic                                                 wr_clk;
  logic                                                 rd_clk;
  logic                                                 rst;
  logic [cdc_fifo_pkg::num_channels-1:0]                ch_wr_en;
  cdc_fifo_pkg::data_t [cdc_fifo_pkg::num_channels-1:0] ch_wr_data;
  logic [cdc_fifo_pkg::num_channels-1:0]                ch_busy;
  logic                                                 full;
  logic                                                 afull;
  logic                                                 rd_en;
  cdc_fifo_pkg::data_t                                  rd_data;
  cdc_fifo_pkg::chan_t                                  rd_chan;
  logic                                                 rd_valid;
  logic                                                 empty;
  logic                                                 aempty;

  cdc_fifo_pkg::data_t exp_q [cdc_fifo_pkg::num_channels][$];
  string               test_name;
  int                  errors;
  int                  read_count;
  int                  match_count;
  int                  cycle_count;
  logic [1:0]          rd_mode;

  cdc_fifo_top cdc_fifo_top_inst (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst        (rst),
    .ch_wr_en   (ch_wr_en),
    .ch_wr_data (ch_wr_data),
    .ch_busy    (ch_busy),
    .full       (full),
    .afull      (afull),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .rd_chan    (rd_chan),
    .rd_valid   (rd_valid),
    .empty      (empty),
    .aempty     (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #4 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #5.5 rd_clk = ~rd_clk;
  end

  task automatic check_equal(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("ERROR %s %s: expected %0d, got %0d", test_name, what, expected, actual);
    end
  endtask

  // Strobe one channel with a random payload and record it.
  task automatic load_channel(input int ch);
    cdc_fifo_pkg::data_t value;
    value = cdc_fifo_pkg::data_t'($urandom);
    ch_wr_en[ch]   = 1'b1;
    ch_wr_data[ch] = value;
    exp_q[ch].push_back(value);
  endtask

  task automatic send_words(input int count0, input int count1, input int chance);
    int left [cdc_fifo_pkg::num_channels];
    left[0] = count0;
    left[1] = count1;
    while (left[0] > 0 || left[1] > 0) begin
      @(posedge wr_clk);
      #1;
      for (int i = 0; i < cdc_fifo_pkg::num_channels; i++) begin
        ch_wr_en[i] = 1'b0;
        if (left[i] > 0 && !ch_busy[i] && ($urandom % 100) < chance) begin
          load_channel(i);
          left[i]--;
        end
      end
    end
    @(posedge wr_clk);
    #1;
    ch_wr_en = '0;
  endtask

  // Both channels strobe in the same cycle once both are idle.
  task automatic send_pairs(input int count);
    for (int n = 0; n < count; n++) begin
      @(posedge wr_clk);
      #1;
      while (ch_busy != '0) begin
        @(posedge wr_clk);
        #1;
      end
      load_channel(0);
      load_channel(1);
      @(posedge wr_clk);
      #1;
      ch_wr_en = '0;
    end
  endtask

  // Read until every expected word has come out.
  task automatic drain_fifo();
    rd_mode = 2'd1;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(posedge wr_clk);
    end
    repeat (3) @(posedge rd_clk);
    #1;
    rd_mode = 2'd0;
    check_equal("empty after drain", 1, int'(empty));
    check_equal("aempty after drain", 1, int'(aempty));
  endtask

  initial begin : reader
    forever begin
      @(posedge rd_clk);
      #1;
      case (rd_mode)
        2'd0: rd_en = 1'b0;
        2'd1: rd_en = 1'b1;
        default: rd_en = ($urandom % 2) == 1;
      endcase
    end
  end

  // Single rd_clk pulse, so each word is seen at exactly one falling edge.
  always @(negedge rd_clk) begin : monitor
    cdc_fifo_pkg::data_t expected;
    if (rd_valid) begin
      read_count++;
      assert (exp_q[rd_chan].size() > 0) else begin
        errors++;
        $display("Word %h on channel %0d arrived in %s with nothing expected",
                 rd_data, rd_chan, test_name);
      end
      if (exp_q[rd_chan].size() > 0) begin
        expected = exp_q[rd_chan].pop_front();
        assert (rd_data == expected) else begin
          errors++;
          $display("ERROR %s channel %0d: expected %h, got %h",
                   test_name, rd_chan, expected, rd_data);
        end
        if (rd_data == expected) begin
          match_count++;
        end
      end
    end
  end

  task automatic reset_state();
    test_name = "reset_state";
    repeat (4) @(posedge wr_clk);
    #1;
    check_equal("empty", 1, int'(empty));
    check_equal("aempty", 1, int'(aempty));
    check_equal("full", 0, int'(full));
    check_equal("afull", 0, int'(afull));
    check_equal("ch_busy", 0, int'(ch_busy));
    check_equal("rd_valid", 0, int'(rd_valid));
  endtask

  task automatic single_channel_order();
    int matches_before;
    test_name = "single_channel_order";
    matches_before = match_count;
    rd_mode = 2'd1;
    send_words(10, 0, 100);
    drain_fifo();
    check_equal("matched words", 10, match_count - matches_before);
  endtask

  task automatic two_channel_share();
    int matches_before;
    test_name = "two_channel_share";
    matches_before = match_count;
    rd_mode = 2'd1;
    send_pairs(12);
    drain_fifo();
    check_equal("matched words", 24, match_count - matches_before);
  endtask

  task automatic fill_and_drain();
    int busy_cycles;
    int reads_before;
    test_name = "fill_and_drain";
    rd_mode = 2'd0;
    busy_cycles = 0;
    while (busy_cycles < 20) begin
      @(posedge wr_clk);
      #1;
      ch_wr_en[0] = 1'b0;
      if (ch_busy[0]) begin
        busy_cycles++;
      end else begin
        busy_cycles = 0;
        load_channel(0);
      end
    end
    repeat (10) @(posedge wr_clk);
    #1;
    check_equal("full", 1, int'(full));
    check_equal("afull", 1, int'(afull));
    check_equal("ch_busy[0]", 1, int'(ch_busy[0]));
    // Sixteen stored plus one pending.
    check_equal("words outstanding", 17, exp_q[0].size());
    reads_before = read_count;
    rd_mode = 2'd1;
    while (full) begin
      @(posedge wr_clk);
      #1;
    end
    check_equal("full fell before drain end", 1, int'(exp_q[0].size() > 0));
    drain_fifo();
    check_equal("words read", 17, read_count - reads_before);
  endtask

  task automatic random_traffic();
    int matches_before;
    test_name = "random_traffic";
    matches_before = match_count;
    rd_mode = 2'd2;
    send_words(150, 150, 40);
    drain_fifo();
    check_equal("matched words", 300, match_count - matches_before);
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge wr_clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d wr_clk cycles in %s", cycle_count, test_name);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(94));
    rst         = 1'b1;
    ch_wr_en    = '0;
    ch_wr_data  = '0;
    rd_en       = 1'b0;
    rd_mode     = 2'd0;
    errors      = 0;
    read_count  = 0;
    match_count = 0;
    test_name   = "startup";
    repeat (8) @(posedge wr_clk);
    #1;
    rst = 1'b0;
    reset_state();
    single_channel_order();
    two_channel_share();
    fill_and_drain();
    random_traffic();
    $display("Summary: %0d errors, %0d words matched", errors, match_count);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
